//--- verif/a2d_stimulus.txt
# set values lft rght batt then expected readings lft rght batt
# all fields hex with one test per line
123 456 789 123 456 789
000 000 000 000 000 000
FFF FFF FFF FFF FFF FFF
000 FFF 000 000 FFF 000
FFF 000 FFF FFF 000 FFF
800 001 7FF 800 001 7FF
001 800 FFE 001 800 FFE
A5A 5A5 3C3 A5A 5A5 3C3
C00 0F0 00F C00 0F0 00F
7FF 800 555 7FF 800 555
AAA 555 CCC AAA 555 CCC
333 999 EEE 333 999 EEE
FFF 000 000 FFF 000 000
000 000 FFF 000 000 FFF

//--- sim.f
+incdir+design
design/a2d_pkg.sv
design/spi_pkg.sv
design/spi_master.sv
design/spi_adc128s.sv
design/adc128s.sv
design/a2d_poller.sv
design/a2d_sense_top.sv
verif/a2d_sense_assert.sv
verif/a2d_sense_tb.sv

//--- Bender.yml
package:
  name: a2d_sense

sources:
  - include_dirs:
      - design
    files:
      - design/a2d_pkg.sv
      - design/spi_pkg.sv
      - design/spi_master.sv
      - design/spi_adc128s.sv
      - design/adc128s.sv
      - design/a2d_poller.sv
      - design/a2d_sense_top.sv
      - target: simulation
        files:
          - verif/a2d_sense_assert.sv
          - verif/a2d_sense_tb.sv

//--- verif/a2d_sense_tb.sv
`timescale 1ns/100ps
`include "a2d_defs.svh"

module a2d_sense_tb import a2d_pkg::*; ();

  // clocks per frame including porches and poller turnaround
  localparam int FRAME_CYC = `FRAME_W * `SCLK_DIV + 8;

  logic              clk;
  logic              rst_n;
  logic              en;
  logic [`A2D_W-1:0] batt_set;
  logic [`A2D_W-1:0] lft_cell_set;
  logic [`A2D_W-1:0] rght_cell_set;
  logic              smpl_vld;
  a2d_chan_e         smpl_chan;
  logic [`A2D_W-1:0] smpl_data;

  // stimulus table, one entry per data line
  logic [`A2D_W-1:0] lft_q[$];
  logic [`A2D_W-1:0] rght_q[$];
  logic [`A2D_W-1:0] batt_q[$];
  logic [`A2D_W-1:0] exp_lft_q[$];
  logic [`A2D_W-1:0] exp_rght_q[$];
  logic [`A2D_W-1:0] exp_batt_q[$];

  int unsigned cycles      = 0;
  int unsigned cycle_limit = 0;

  a2d_sense_top UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .en            (en),
    .batt_set      (batt_set),
    .lft_cell_set  (lft_cell_set),
    .rght_cell_set (rght_cell_set),
    .smpl_vld      (smpl_vld),
    .smpl_chan     (smpl_chan),
    .smpl_data     (smpl_data)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  // cycle watchdog armed once the table is loaded
  always @(posedge clk) begin
    cycles = cycles + 1;
    if ((cycle_limit != 0) && (cycles >= cycle_limit)) begin
      $display("timeout after %0d cycles without the expected samples", cycles);
      $display("Simulation FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic check_val(input string what, input logic [15:0] act,
                           input logic [15:0] exp);
    if (act !== exp) begin
      $display("mismatch at %0t ns: %s read %h expected %h", $time, what, act, exp);
      $display("Simulation FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  // lines that are not six hex fields are notes and get skipped
  task automatic load_stimulus();
    int                fd;
    int                n;
    string             line;
    logic [`A2D_W-1:0] s_l;
    logic [`A2D_W-1:0] s_r;
    logic [`A2D_W-1:0] s_b;
    logic [`A2D_W-1:0] e_l;
    logic [`A2D_W-1:0] e_r;
    logic [`A2D_W-1:0] e_b;
    fd = $fopen("verif/a2d_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open verif/a2d_stimulus.txt");
      $display("Simulation FAILED");
      $fatal(1, "stimulus file missing");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0) begin
        n = $sscanf(line, "%h %h %h %h %h %h", s_l, s_r, s_b, e_l, e_r, e_b);
        if (n == 6) begin
          lft_q.push_back(s_l);
          rght_q.push_back(s_r);
          batt_q.push_back(s_b);
          exp_lft_q.push_back(e_l);
          exp_rght_q.push_back(e_r);
          exp_batt_q.push_back(e_b);
        end
      end
    end
    $fclose(fd);
  endtask

  // new set values and en go in just after an edge
  task automatic drive_sets(input logic [`A2D_W-1:0] l, input logic [`A2D_W-1:0] r,
                            input logic [`A2D_W-1:0] b);
    @(posedge clk);
    #1;
    lft_cell_set  = l;
    rght_cell_set = r;
    batt_set      = b;
    en            = 1'b1;
  endtask

  // short drop of en between tests
  task automatic pause_en(input int n);
    if (n > 0) begin
      @(posedge clk);
      #1 en = 1'b0;
      repeat (n - 1) @(posedge clk);
      @(posedge clk);
      #1 en = 1'b1;
    end
  endtask

  // outputs sampled on the falling edge in mid cycle
  task automatic wait_sample(output a2d_chan_e ch, output logic [`A2D_W-1:0] data);
    @(negedge clk);
    while (!smpl_vld) begin
      @(negedge clk);
    end
    ch   = smpl_chan;
    data = smpl_data;
  endtask

  // drop everything up to the end of the round in flight
  task automatic skip_round();
    a2d_chan_e         ch;
    logic [`A2D_W-1:0] data;
    do begin
      wait_sample(ch, data);
    end while (ch != BATT);
  endtask

  // one full rotation where each reply is the set input of its channel
  task automatic check_round(input logic [`A2D_W-1:0] e_l, input logic [`A2D_W-1:0] e_r,
                             input logic [`A2D_W-1:0] e_b);
    a2d_chan_e         ch;
    logic [`A2D_W-1:0] data;
    wait_sample(ch, data);
    check_val("channel of LFT slot", ch, LFT);
    check_val("LFT reading", data, e_l);
    wait_sample(ch, data);
    check_val("channel of RGHT slot", ch, RGHT);
    check_val("RGHT reading", data, e_r);
    wait_sample(ch, data);
    check_val("channel of BATT slot", ch, BATT);
    check_val("BATT reading", data, e_b);
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin
    a2d_chan_e         ch;
    logic [`A2D_W-1:0] data;
    logic [`A2D_W-1:0] new_lft;
    int                idle;
    int                assert_errs;

    rst_n         = 1'b0;
    en            = 1'b0;
    lft_cell_set  = '0;
    rght_cell_set = '0;
    batt_set      = '0;
    void'($urandom(36962));

    load_stimulus();
    if (lft_q.size() == 0) begin
      $display("no usable lines in verif/a2d_stimulus.txt");
      $display("Simulation FAILED");
      $fatal(1, "empty stimulus");
    end
    // two rounds of six frames per line plus one slot for the en stop test
    cycle_limit = (lft_q.size() + 1) * 2 * 6 * FRAME_CYC * 2;

    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;

    // disabled poller stays silent
    repeat (100) begin
      @(negedge clk);
      check_val("smpl_vld with en low", smpl_vld, 16'(1'b0));
    end

    // table driven rounds with the extremes in the data
    foreach (lft_q[i]) begin
      idle = $urandom_range(3, 0);
      pause_en(idle);
      drive_sets(lft_q[i], rght_q[i], batt_q[i]);
      skip_round();
      check_round(exp_lft_q[i], exp_rght_q[i], exp_batt_q[i]);
    end

    // en drops right after the LFT pulse while the RGHT pair is already issued
    do begin
      wait_sample(ch, data);
    end while (ch != LFT);
    @(posedge clk);
    #1 en = 1'b0;
    wait_sample(ch, data);
    check_val("channel finishing after en low", ch, RGHT);
    check_val("RGHT reading after en low", data, exp_rght_q[$]);
    repeat (2 * FRAME_CYC) begin
      @(negedge clk);
      check_val("smpl_vld after stop", smpl_vld, 16'(1'b0));
    end

    // restart begins at LFT with the fresh value
    new_lft = `A2D_W'($urandom_range(4095, 0));
    drive_sets(new_lft, rght_cell_set, batt_set);
    check_round(new_lft, exp_rght_q[$], exp_batt_q[$]);

    assert_errs = UUT.u_assert.err_cnt;
    if (assert_errs == 0) begin
      $display("Simulation PASSED");
      $finish;
    end else begin
      $display("%0d protocol assertions failed", assert_errs);
      $display("Simulation FAILED");
      $fatal(1, "assertion failures");
    end
  end

endmodule

//--- verif/a2d_sense_assert.sv
`timescale 1ns/100ps

module a2d_sense_assert import a2d_pkg::*; (
  input logic      clk,
  input logic      rst_n,
  input logic      SS_n,
  input logic      SCLK,
  input logic      done,
  input logic      smpl_vld,
  input a2d_chan_e channel
);

  // running count of failed assertions
  int err_cnt = 0;

  // sclk parks high outside a frame
  sclk_idle_high: assert property (
    @(posedge clk) disable iff (!rst_n) SS_n |-> SCLK
  ) else begin
    $error("SCLK low while SS_n high");
    err_cnt++;
  end

  // done is a single cycle pulse
  done_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) done |=> !done
  ) else begin
    $error("done held for more than one cycle");
    err_cnt++;
  end

  // only the three wired inputs are ever selected
  chan_legal: assert property (
    @(posedge clk) disable iff (!rst_n) channel inside {LFT, RGHT, BATT}
  ) else begin
    $error("channel pointer left the LFT RGHT BATT set");
    err_cnt++;
  end

  // one sample strobe per pair and never back to back
  vld_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) smpl_vld |=> !smpl_vld
  ) else begin
    $error("smpl_vld high on two consecutive cycles");
    err_cnt++;
  end

endmodule

// spi link, done and sample strobe of the top level plus the converter pointer
bind a2d_sense_top a2d_sense_assert u_assert (
  .clk      (clk),
  .rst_n    (rst_n),
  .SS_n     (ss_n),
  .SCLK     (sclk),
  .done     (done),
  .smpl_vld (smpl_vld),
  .channel  (u_adc.channel)
);

//--- design/a2d_sense_top.sv
`timescale 1ns/100ps
`include "a2d_defs.svh"

module a2d_sense_top import a2d_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              en,
  input  logic [`A2D_W-1:0] batt_set,
  input  logic [`A2D_W-1:0] lft_cell_set,
  input  logic [`A2D_W-1:0] rght_cell_set,
  output logic              smpl_vld,
  output a2d_chan_e         smpl_chan,
  output logic [`A2D_W-1:0] smpl_data
);

  // poller to master
  logic                wrt;
  logic                done;
  logic [`FRAME_W-1:0] cmd;
  logic [`FRAME_W-1:0] rd_data;
  // spi link
  logic                ss_n;
  logic                sclk;
  logic                mosi;
  logic                miso;

  a2d_poller u_poller (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .done      (done),
    .rd_data   (rd_data),
    .wrt       (wrt),
    .cmd       (cmd),
    .smpl_vld  (smpl_vld),
    .smpl_chan (smpl_chan),
    .smpl_data (smpl_data)
  );

  spi_master u_spi_master (
    .clk     (clk),
    .rst_n   (rst_n),
    .wrt     (wrt),
    .cmd     (cmd),
    .MISO    (miso),
    .SS_n    (ss_n),
    .SCLK    (sclk),
    .MOSI    (mosi),
    .done    (done),
    .rd_data (rd_data)
  );

  adc128s u_adc (
    .clk           (clk),
    .rst_n         (rst_n),
    .SS_n          (ss_n),
    .SCLK          (sclk),
    .MOSI          (mosi),
    .batt_set      (batt_set),
    .lft_cell_set  (lft_cell_set),
    .rght_cell_set (rght_cell_set),
    .MISO          (miso)
  );

endmodule

//--- design/a2d_poller.sv
`timescale 1ns/100ps
`include "a2d_defs.svh"

module a2d_poller import a2d_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                en,
  input  logic                done,
  input  logic [`FRAME_W-1:0] rd_data,
  output logic                wrt,
  output logic [`FRAME_W-1:0] cmd,
  output logic                smpl_vld,
  output a2d_chan_e           smpl_chan,
  output logic [`A2D_W-1:0]   smpl_data
);

  a2d_chan_e  chan;
  cmd_phase_e phase;
  logic       busy;
  logic       issue;
  logic       pair_end;

  // rotation lft, rght, batt
  function automatic a2d_chan_e next_chan(input a2d_chan_e cur);
    case (cur)
      LFT:     next_chan = RGHT;
      RGHT:    next_chan = BATT;
      default: next_chan = LFT;
    endcase
  endfunction

  // a pending second frame goes out even after en drops
  assign issue    = !busy && (en || (phase == SECOND));
  assign pair_end = done && (phase == SECOND);

  //////////////////////////////
  // channel sequencer
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wrt      <= 1'b0;
      busy     <= 1'b0;
      phase    <= FIRST;
      chan     <= LFT;
      smpl_vld <= 1'b0;
    end else begin
      wrt      <= issue;
      smpl_vld <= pair_end;
      if (issue) begin
        busy <= 1'b1;
      end else if (done) begin
        busy  <= 1'b0;
        phase <= (phase == FIRST) ? SECOND : FIRST;
        if (phase == SECOND) begin
          chan <= next_chan(chan);
        end
      end else if (!busy && !en && (phase == FIRST)) begin
        // stopped between pairs, restart at lft
        chan <= LFT;
      end
    end
  end

  // command held for the whole frame, result held until next pulse
  always_ff @(posedge clk) begin
    if (issue) begin
      cmd <= {2'b00, chan, 11'h000};
    end
    if (pair_end) begin
      smpl_data <= rd_data[`A2D_W-1:0];
      smpl_chan <= chan;
    end
  end

endmodule

//--- design/adc128s.sv
`timescale 1ns/100ps
`include "a2d_defs.svh"

module adc128s import a2d_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              SS_n,
  input  logic              SCLK,
  input  logic              MOSI,
  input  logic [`A2D_W-1:0] batt_set,
  input  logic [`A2D_W-1:0] lft_cell_set,
  input  logic [`A2D_W-1:0] rght_cell_set,
  output logic              MISO
);

  logic [`FRAME_W-1:0] cmd;
  logic [`FRAME_W-1:0] a2d_data;
  logic                rdy;
  logic                rdy_ff;
  logic                rdy_rise;
  logic                update_ch;
  logic                load_val;
  cmd_phase_e          phase;
  a2d_chan_e           channel;
  logic [`A2D_W-1:0]   value;

  // reply is the 12 bit value, upper bits zero
  assign a2d_data = {{(`FRAME_W - `A2D_W){1'b0}}, value};

  spi_adc128s u_spi (
    .clk      (clk),
    .rst_n    (rst_n),
    .SS_n     (SS_n),
    .SCLK     (SCLK),
    .MOSI     (MOSI),
    .A2D_data (a2d_data),
    .MISO     (MISO),
    .cmd      (cmd),
    .rdy      (rdy)
  );

  assign rdy_rise  = rdy & ~rdy_ff;
  assign update_ch = rdy_rise && (phase == FIRST);

  //////////////////////////////
  // frame pair and channel pointer
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_ff   <= 1'b0;
      load_val <= 1'b0;
      phase    <= FIRST;
      channel  <= LFT;
    end else begin
      rdy_ff   <= rdy;
      load_val <= update_ch;
      if (rdy_rise) begin
        phase <= (phase == FIRST) ? SECOND : FIRST;
      end
      // channel field sits in cmd[13:11]
      if (update_ch) begin
        channel <= a2d_chan_e'(cmd[13:11]);
      end
    end
  end

  // value follows the new pointer one cycle later
  // unwired channels keep the last value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      value <= 12'hC00;
    end else if (load_val) begin
      case (channel)
        LFT:     value <= lft_cell_set;
        RGHT:    value <= rght_cell_set;
        BATT:    value <= batt_set;
        default: value <= value;
      endcase
    end
  end

endmodule

//--- design/spi_adc128s.sv
`timescale 1ns/100ps
`include "a2d_defs.svh"

module spi_adc128s (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                SS_n,
  input  logic                SCLK,
  input  logic                MOSI,
  input  logic [`FRAME_W-1:0] A2D_data,
  output logic                MISO,
  output logic [`FRAME_W-1:0] cmd,
  output logic                rdy
);

  // [1:0] synchronizer, [2] previous value for edge detect
  logic [2:0]          ss_sync;
  logic [2:0]          sclk_sync;
  logic [1:0]          mosi_sync;
  logic                ss_fall;
  logic                ss_rise;
  logic                sclk_rise;
  logic                sclk_fall;
  logic                frame_act;
  logic                armed;
  logic                shift_en;
  logic                mosi_smpl;
  logic [`FRAME_W-1:0] shft;

  //////////////////////////////
  // input synchronizers
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ss_sync   <= 3'b111;
      sclk_sync <= 3'b111;
      mosi_sync <= 2'b00;
    end else begin
      ss_sync   <= {ss_sync[1:0], SS_n};
      sclk_sync <= {sclk_sync[1:0], SCLK};
      mosi_sync <= {mosi_sync[0], MOSI};
    end
  end

  assign frame_act = ~ss_sync[1];
  assign ss_fall   = ~ss_sync[1] & ss_sync[2];
  assign ss_rise   = ss_sync[1] & ~ss_sync[2];
  assign sclk_rise = frame_act & sclk_sync[1] & ~sclk_sync[2];
  assign sclk_fall = frame_act & ~sclk_sync[1] & sclk_sync[2];

  // first fall comes before any rise and must not shift the msb away
  // ss_n rise supplies the shift the last bit would get from a fall
  assign shift_en = armed & (sclk_fall | ss_rise);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      armed <= 1'b0;
      rdy   <= 1'b0;
    end else begin
      rdy <= ss_rise;
      if (ss_fall) begin
        armed <= 1'b0;
      end else if (sclk_rise) begin
        armed <= 1'b1;
      end
    end
  end

  // reply loads at frame start, command builds up behind it
  always_ff @(posedge clk) begin
    if (ss_fall) begin
      shft <= A2D_data;
    end else if (shift_en) begin
      shft <= {shft[`FRAME_W-2:0], mosi_smpl};
    end
    if (sclk_rise) begin
      mosi_smpl <= mosi_sync[1];
    end
  end

  assign MISO = shft[`FRAME_W-1];
  assign cmd  = shft;

endmodule

//--- design/spi_master.sv
`timescale 1ns/100ps
`include "a2d_defs.svh"

module spi_master import spi_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wrt,
  input  logic [`FRAME_W-1:0] cmd,
  input  logic                MISO,
  output logic                SS_n,
  output logic                SCLK,
  output logic                MOSI,
  output logic                done,
  output logic [`FRAME_W-1:0] rd_data
);

  localparam int CNT_W = $clog2(`SCLK_DIV);
  localparam int BIT_W = $clog2(`FRAME_W);
  localparam logic [CNT_W-1:0] HALF_END = CNT_W'(`SCLK_DIV / 2 - 1);
  localparam logic [CNT_W-1:0] FULL_END = CNT_W'(`SCLK_DIV - 1);
  localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`FRAME_W - 1);

  spi_state_e          state;
  logic [CNT_W-1:0]    div_cnt;
  logic [BIT_W-1:0]    bit_cnt;
  logic [`FRAME_W-1:0] shft;
  logic                miso_smpl;
  logic                at_half;
  logic                at_full;

  // sclk rises at mid period and falls at period end
  assign at_half = (state == SHIFT) && (div_cnt == HALF_END);
  assign at_full = (state == SHIFT) && (div_cnt == FULL_END);

  //////////////////////////////
  // sequencer and sclk divider
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      SS_n    <= 1'b1;
      SCLK    <= 1'b1;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (wrt) begin
            SS_n    <= 1'b0;
            div_cnt <= '0;
            state   <= FRONT;
          end
        end
        FRONT: begin
          // first fall after half a period with ss_n low
          div_cnt <= div_cnt + 1'b1;
          if (div_cnt == HALF_END) begin
            SCLK    <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            state   <= SHIFT;
          end
        end
        SHIFT: begin
          div_cnt <= div_cnt + 1'b1;
          if (at_half) begin
            SCLK <= 1'b1;
          end
          if (at_full) begin
            div_cnt <= '0;
            if (bit_cnt == LAST_BIT) begin
              // sclk stays high, frame closes
              SS_n  <= 1'b1;
              state <= BACK;
            end else begin
              SCLK    <= 1'b0;
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        BACK: begin
          // done lands two cycles after ss_n rise
          div_cnt <= div_cnt + 1'b1;
          if (div_cnt == CNT_W'(1)) begin
            done  <= 1'b1;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // one register carries cmd out and the reply in
  always_ff @(posedge clk) begin
    if ((state == IDLE) && wrt) begin
      shft <= cmd;
    end else if (at_full) begin
      shft <= {shft[`FRAME_W-2:0], miso_smpl};
    end
    // miso captured on the rise, shifted in on the next fall
    if (at_half) begin
      miso_smpl <= MISO;
    end
  end

  assign MOSI    = shft[`FRAME_W-1];
  assign rd_data = shft;

endmodule

//--- design/spi_pkg.sv
package spi_pkg;

  // spi master sequence
  // idle    ss_n high, sclk high
  // front   half period porch before first fall
  // shift   sixteen sclk periods
  // back    wait after ss_n rises, then done
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    FRONT = 2'd1,
    SHIFT = 2'd2,
    BACK  = 2'd3
  } spi_state_e;

endpackage

//--- design/a2d_pkg.sv
`include "a2d_defs.svh"

package a2d_pkg;

  // the eight converter inputs
  // only lft, rght and batt are wired in this subsystem
  typedef enum logic [2:0] {
    LFT  = `CH_LFT,
    AIN1 = 3'd1,
    AIN2 = 3'd2,
    AIN3 = 3'd3,
    RGHT = `CH_RGHT,
    BATT = `CH_BATT,
    AIN6 = 3'd6,
    AIN7 = 3'd7
  } a2d_chan_e;

  // first frame of a pair selects the channel and the second returns it
  typedef enum logic {
    FIRST  = 1'b0,
    SECOND = 1'b1
  } cmd_phase_e;

endpackage

//--- design/a2d_defs.svh
`ifndef A2D_DEFS_SVH
`define A2D_DEFS_SVH

// sample width of the converter
`define A2D_W 12

// bits per spi frame, command and reply alike
`define FRAME_W 16

// system clocks per sclk period, kept even so both halves match
`define SCLK_DIV 32

//////////////////////////////
// converter channel codes
//////////////////////////////
// left load cell
`define CH_LFT 3'd0
// right load cell
`define CH_RGHT 3'd4
// battery divider
`define CH_BATT 3'd5

`endif
